/* verilog/mbox_cfg_pkg.sv */
// ----------------------------------------------------------
// datapath sizes of the mailbox, shared by fifo, ports and top
// import it wherever a word, a count or an index is needed
// ----------------------------------------------------------

package mbox_cfg_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------
  localparam int unsigned DATA_W = 32;             // mailbox word
  localparam int unsigned DEPTH  = 8;              // words per fifo, at least 2
  localparam int unsigned CNT_W  = 4;              // holds 0 .. DEPTH
  localparam int unsigned PTR_W  = $clog2(DEPTH);  // fifo read/write pointer
  localparam int unsigned ADDR_W = 4;              // port register index

  // ----------------------------------------------------------
  // vector types
  // ----------------------------------------------------------
  typedef logic [DATA_W-1:0] data_t;  // one mailbox word
  // fill count, msb set only when full, also used for thresholds
  typedef logic [CNT_W-1:0]  cnt_t;
  typedef logic [ADDR_W-1:0] addr_t;  // word index, no byte offset

endpackage

/* verilog/mbox_reg_pkg.sv */
// ----------------------------------------------------------
// register map of one mailbox port, field positions inside the
// registers and the fixed values returned on special reads
// ----------------------------------------------------------

package mbox_reg_pkg;

  // ----------------------------------------------------------
  // register indices
  // ----------------------------------------------------------
  localparam mbox_cfg_pkg::addr_t REG_MBOXW  = mbox_cfg_pkg::addr_t'(0); // push word
  localparam mbox_cfg_pkg::addr_t REG_MBOXR  = mbox_cfg_pkg::addr_t'(1); // pop word
  localparam mbox_cfg_pkg::addr_t REG_STATUS = mbox_cfg_pkg::addr_t'(2); // read only
  localparam mbox_cfg_pkg::addr_t REG_ERROR  = mbox_cfg_pkg::addr_t'(3); // clear on read
  localparam mbox_cfg_pkg::addr_t REG_WIRQT  = mbox_cfg_pkg::addr_t'(4); // write threshold
  localparam mbox_cfg_pkg::addr_t REG_RIRQT  = mbox_cfg_pkg::addr_t'(5); // read threshold
  localparam mbox_cfg_pkg::addr_t REG_IRQS   = mbox_cfg_pkg::addr_t'(6); // write 1 to clear
  localparam mbox_cfg_pkg::addr_t REG_IRQEN  = mbox_cfg_pkg::addr_t'(7);
  localparam mbox_cfg_pkg::addr_t REG_IRQP   = mbox_cfg_pkg::addr_t'(8); // read only
  localparam mbox_cfg_pkg::addr_t REG_CTRL   = mbox_cfg_pkg::addr_t'(9); // flush pulses

  localparam int unsigned NUM_REGS = 10;  // anything at or above is a decode error

  // ----------------------------------------------------------
  // bit positions
  // ----------------------------------------------------------
  localparam int unsigned ST_EMPTY     = 0;  // incoming fifo empty
  localparam int unsigned ST_FULL      = 1;  // outgoing fifo full
  localparam int unsigned ST_WTHR      = 2;  // outgoing count above WIRQT
  localparam int unsigned ST_RTHR      = 3;  // incoming count above RIRQT

  localparam int unsigned ERR_RD_EMPTY = 0;
  localparam int unsigned ERR_WR_FULL  = 1;

  localparam int unsigned IRQ_W        = 0;
  localparam int unsigned IRQ_R        = 1;
  localparam int unsigned IRQ_ERR      = 2;

  localparam int unsigned CTRL_FLUSH_W = 0;
  localparam int unsigned CTRL_FLUSH_R = 1;

  // fixed read data
  localparam mbox_cfg_pkg::data_t MBOXW_READ_VAL = 32'hFEEDC0DE; // MBOXW is write only
  localparam mbox_cfg_pkg::data_t EMPTY_READ_VAL = 32'hFEEDDEAD; // pop from empty fifo

  typedef logic [2:0] irq_vec_t;  // indexed by IRQ_*
  typedef logic [1:0] err_vec_t;  // indexed by ERR_*

endpackage

/* verilog/mbox_fifo.sv */
// ----------------------------------------------------------
// single clock mailbox fifo, head word is registered storage
// push/pop are ignored when full/empty, flush wins over both
// ----------------------------------------------------------

`timescale 1ns/1ps

module mbox_fifo (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                flush_i,   // drop all words at next edge
  input  logic                push_i,
  input  mbox_cfg_pkg::data_t data_i,
  input  logic                pop_i,
  output mbox_cfg_pkg::data_t data_o,    // head word, valid when not empty
  output logic                full_o,
  output logic                empty_o,
  output mbox_cfg_pkg::cnt_t  cnt_o      // 0 .. DEPTH
);

  import mbox_cfg_pkg::*;

  typedef logic [PTR_W-1:0] ptr_t;

  data_t mem_q [DEPTH];     // storage, no reset
  ptr_t  wr_ptr_q;          // next free slot
  ptr_t  rd_ptr_q;          // head slot
  cnt_t  cnt_q;             // occupancy
  logic  do_push, do_pop;   // qualified strobes

  // wrap at DEPTH-1 so non power of two depths work too
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    ptr_t nxt;
    if (ptr == ptr_t'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + ptr_t'(1);
    end
    return nxt;
  endfunction

  assign full_o  = (cnt_q == cnt_t'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i & ~full_o;   // overflow is dropped
  assign do_pop  = pop_i & ~empty_o;   // underflow is dropped
  assign data_o  = mem_q[rd_ptr_q];    // no fall through
  assign cnt_o   = cnt_q;

  // ----------------------------------------------------------
  // pointers and count
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;   // flush overrides push and pop
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;   // both or none, count unchanged
      endcase
    end
  end

  // storage write
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* verilog/mbox_port_regs.sv */
// ----------------------------------------------------------
// register file of one mailbox port: decodes word accesses,
// drives push/pop/flush of both fifos, keeps thresholds, errors
// and the level interrupt, answers every request one cycle later
// ----------------------------------------------------------

`timescale 1ns/1ps

module mbox_port_regs (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // access port
  input  logic                req_i,       // one cycle strobe
  input  logic                we_i,
  input  mbox_cfg_pkg::addr_t addr_i,      // word index
  input  mbox_cfg_pkg::data_t wdata_i,
  output logic                rsp_o,       // one cycle after req_i
  output logic                err_o,
  output mbox_cfg_pkg::data_t rdata_o,
  output logic                irq_o,       // level, active high
  // outgoing fifo
  output mbox_cfg_pkg::data_t wr_data_o,
  output logic                wr_push_o,
  input  logic                wr_full_i,
  input  mbox_cfg_pkg::cnt_t  wr_cnt_i,
  // incoming fifo
  input  mbox_cfg_pkg::data_t rd_data_i,
  input  logic                rd_empty_i,
  input  mbox_cfg_pkg::cnt_t  rd_cnt_i,
  output logic                rd_pop_o,
  // flush requests, ORed in the top level
  output logic                flush_w_o,
  output logic                flush_r_o
);

  import mbox_cfg_pkg::*;
  import mbox_reg_pkg::*;

  // ----------------------------------------------------------
  // state
  // ----------------------------------------------------------
  err_vec_t error_q,  error_d;   // sticky error flags
  irq_vec_t irqs_q,   irqs_d;    // interrupt status
  irq_vec_t irqen_q,  irqen_d;   // interrupt enable
  cnt_t     wirqt_q,  wirqt_d;   // write threshold, max DEPTH-1
  cnt_t     rirqt_q,  rirqt_d;   // read threshold, max DEPTH-1
  irq_vec_t irq_clr;             // ones written to IRQS

  // response register
  logic     rsp_q;
  logic     err_q,    err_d;
  data_t    rdata_q,  rdata_d;
  logic     irq_q;

  // combinational registers
  logic [3:0] status;            // indexed by ST_*
  irq_vec_t   irqp;              // pending = status & enable
  logic       addr_ok;           // index inside the map
  logic       rd_req, wr_req;

  // a threshold at or above DEPTH could never trip, pull it to DEPTH-1
  function automatic cnt_t clamp_thr(input data_t val);
    cnt_t res;
    if (val >= data_t'(DEPTH - 1)) begin
      res = cnt_t'(DEPTH - 1);
    end else begin
      res = cnt_t'(val);
    end
    return res;
  endfunction

  assign addr_ok = (32'(addr_i) < NUM_REGS);
  assign rd_req  = req_i & ~we_i;
  assign wr_req  = req_i & we_i;

  assign status[ST_EMPTY] = rd_empty_i;
  assign status[ST_FULL]  = wr_full_i;
  assign status[ST_WTHR]  = (wr_cnt_i > wirqt_q);   // count includes full state
  assign status[ST_RTHR]  = (rd_cnt_i > rirqt_q);

  assign irqp      = irqs_q & irqen_q;
  assign wr_data_o = wdata_i;   // full word writes only

  // ----------------------------------------------------------
  // access decode and register next state
  // ----------------------------------------------------------
  always_comb begin
    error_d   = error_q;
    irqen_d   = irqen_q;
    wirqt_d   = wirqt_q;
    rirqt_d   = rirqt_q;
    irq_clr   = '0;
    err_d     = req_i;          // error unless decoded below
    rdata_d   = '0;             // writes and bad reads return zero
    wr_push_o = 1'b0;
    rd_pop_o  = 1'b0;
    flush_w_o = 1'b0;
    flush_r_o = 1'b0;

    // threshold sources are level set
    irqs_d          = irqs_q;
    irqs_d[IRQ_W]   = irqs_q[IRQ_W] | status[ST_WTHR];
    irqs_d[IRQ_R]   = irqs_q[IRQ_R] | status[ST_RTHR];

    // reads
    if (rd_req && addr_ok) begin
      err_d = 1'b0;
      case (addr_i)
        REG_MBOXW:  rdata_d = MBOXW_READ_VAL;
        REG_MBOXR: begin
          if (rd_empty_i) begin
            rdata_d               = EMPTY_READ_VAL;
            err_d                 = 1'b1;
            error_d[ERR_RD_EMPTY] = 1'b1;
            irqs_d[IRQ_ERR]       = 1'b1;
          end else begin
            rdata_d  = rd_data_i;
            rd_pop_o = 1'b1;       // head leaves at next edge
          end
        end
        REG_STATUS: rdata_d = data_t'(status);
        REG_ERROR: begin
          rdata_d = data_t'(error_q);
          error_d = '0;            // clear on read
        end
        REG_WIRQT:  rdata_d = data_t'(wirqt_q);
        REG_RIRQT:  rdata_d = data_t'(rirqt_q);
        REG_IRQS:   rdata_d = data_t'(irqs_q);
        REG_IRQEN:  rdata_d = data_t'(irqen_q);
        REG_IRQP:   rdata_d = data_t'(irqp);
        REG_CTRL:   rdata_d = '0;  // flush bits are pulses
        default:    rdata_d = '0;
      endcase
    end

    // writes, read only registers keep the error default
    if (wr_req && addr_ok) begin
      case (addr_i)
        REG_MBOXW: begin
          if (wr_full_i) begin
            error_d[ERR_WR_FULL] = 1'b1;
            irqs_d[IRQ_ERR]      = 1'b1;
          end else begin
            wr_push_o = 1'b1;
            err_d     = 1'b0;
          end
        end
        REG_WIRQT: begin
          wirqt_d = clamp_thr(wdata_i);
          err_d   = 1'b0;
        end
        REG_RIRQT: begin
          rirqt_d = clamp_thr(wdata_i);
          err_d   = 1'b0;
        end
        REG_IRQS: begin
          irq_clr = irq_vec_t'(wdata_i);
          err_d   = 1'b0;
        end
        REG_IRQEN: begin
          irqen_d = irq_vec_t'(wdata_i);
          err_d   = 1'b0;
        end
        REG_CTRL: begin
          flush_w_o = wdata_i[CTRL_FLUSH_W];
          flush_r_o = wdata_i[CTRL_FLUSH_R];
          err_d     = 1'b0;
        end
        default: err_d = 1'b1;     // MBOXR, STATUS, ERROR, IRQP
      endcase
    end

    // acknowledge goes last so it beats a set in the same cycle
    irqs_d = irqs_d & ~irq_clr;
  end

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      error_q <= '0;
      irqs_q  <= '0;
      irqen_q <= '0;
      wirqt_q <= '0;
      rirqt_q <= '0;
      rsp_q   <= 1'b0;
      err_q   <= 1'b0;
      rdata_q <= '0;
      irq_q   <= 1'b0;
    end else begin
      error_q <= error_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
      wirqt_q <= wirqt_d;
      rirqt_q <= rirqt_d;
      rsp_q   <= req_i;    // fixed one cycle latency
      err_q   <= err_d;
      rdata_q <= rdata_d;
      irq_q   <= |irqp;    // one cycle after IRQS/IRQEN change
    end
  end

  assign rsp_o   = rsp_q;
  assign err_o   = err_q;
  assign rdata_o = rdata_q;
  assign irq_o   = irq_q;

endmodule

/* verilog/mbox_top.sv */
// ----------------------------------------------------------
// two port mailbox top: each port pushes into one fifo and
// pops from the other, flushes are merged per fifo
// ----------------------------------------------------------

`timescale 1ns/1ps

module mbox_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // port 0
  input  logic                p0_req_i,
  input  logic                p0_we_i,
  input  mbox_cfg_pkg::addr_t p0_addr_i,
  input  mbox_cfg_pkg::data_t p0_wdata_i,
  output logic                p0_rsp_o,
  output logic                p0_err_o,
  output mbox_cfg_pkg::data_t p0_rdata_o,
  output logic                p0_irq_o,
  // port 1
  input  logic                p1_req_i,
  input  logic                p1_we_i,
  input  mbox_cfg_pkg::addr_t p1_addr_i,
  input  mbox_cfg_pkg::data_t p1_wdata_i,
  output logic                p1_rsp_o,
  output logic                p1_err_o,
  output mbox_cfg_pkg::data_t p1_rdata_o,
  output logic                p1_irq_o
);

  import mbox_cfg_pkg::*;

  // ----------------------------------------------------------
  // fifo side nets, index is the port
  // ----------------------------------------------------------
  data_t [1:0] wr_data, rd_data;
  logic  [1:0] push, pop;
  logic  [1:0] flush_w, flush_r;
  logic  [1:0] full, empty;        // index is the writing port
  cnt_t  [1:0] cnt;                // index is the writing port

  mbox_port_regs u_port0 (
    .clk_i, .arst_n_i,
    .req_i   (p0_req_i),   .we_i    (p0_we_i),
    .addr_i  (p0_addr_i),  .wdata_i (p0_wdata_i),
    .rsp_o   (p0_rsp_o),   .err_o   (p0_err_o),
    .rdata_o (p0_rdata_o), .irq_o   (p0_irq_o),
    .wr_data_o (wr_data[0]), .wr_push_o (push[0]),       // out via 0 to 1
    .wr_full_i (full[0]),    .wr_cnt_i  (cnt[0]),
    .rd_data_i (rd_data[0]), .rd_empty_i (empty[1]),     // in via 1 to 0
    .rd_cnt_i  (cnt[1]),     .rd_pop_o  (pop[0]),
    .flush_w_o (flush_w[0]), .flush_r_o (flush_r[0])
  );

  mbox_port_regs u_port1 (
    .clk_i, .arst_n_i,
    .req_i   (p1_req_i),   .we_i    (p1_we_i),
    .addr_i  (p1_addr_i),  .wdata_i (p1_wdata_i),
    .rsp_o   (p1_rsp_o),   .err_o   (p1_err_o),
    .rdata_o (p1_rdata_o), .irq_o   (p1_irq_o),
    .wr_data_o (wr_data[1]), .wr_push_o (push[1]),       // out via 1 to 0
    .wr_full_i (full[1]),    .wr_cnt_i  (cnt[1]),
    .rd_data_i (rd_data[1]), .rd_empty_i (empty[0]),     // in via 0 to 1
    .rd_cnt_i  (cnt[0]),     .rd_pop_o  (pop[1]),
    .flush_w_o (flush_w[1]), .flush_r_o (flush_r[1])
  );

  // either end may flush a fifo
  mbox_fifo u_fifo_0to1 (
    .clk_i, .arst_n_i,
    .flush_i (flush_w[0] | flush_r[1]),
    .push_i  (push[0]),  .data_i  (wr_data[0]),
    .pop_i   (pop[1]),   .data_o  (rd_data[1]),
    .full_o  (full[0]),  .empty_o (empty[0]), .cnt_o (cnt[0])
  );

  mbox_fifo u_fifo_1to0 (
    .clk_i, .arst_n_i,
    .flush_i (flush_w[1] | flush_r[0]),
    .push_i  (push[1]),  .data_i  (wr_data[1]),
    .pop_i   (pop[0]),   .data_o  (rd_data[0]),
    .full_o  (full[1]),  .empty_o (empty[1]), .cnt_o (cnt[1])
  );

endmodule

/* tb/tb_clk_gen.sv */
// ----------------------------------------------------------
// clock and reset source of the mailbox testbench
// 40 ns clock, reset held low for the first 16 cycles
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HALF_NS    = 20,  // half period
  parameter int unsigned RST_CYCLES = 16
) (
  output logic clk_o,
  output logic arst_n_o   // async, active low
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // release just after an edge, same offset as the stimulus
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 arst_n_o = 1'b1;
  end

endmodule

/* tb/mbox_port_chk.sv */
// ----------------------------------------------------------
// protocol and interrupt assertions, bound into every
// mbox_port_regs instance of the design
// ----------------------------------------------------------

`timescale 1ns/1ps

module mbox_port_chk (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input logic                    req_i,
  input logic                    rsp_i,
  input logic                    wr_push_i,
  input logic                    wr_full_i,
  input logic                    rd_pop_i,
  input logic                    rd_empty_i,
  input logic                    irq_i,
  input mbox_reg_pkg::irq_vec_t  irqen_i    // enable register of the port
);

  // fixed one cycle latency in both directions
  rsp_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i |=> rsp_i) else $error("no response one cycle after a request");

  no_rsp_without_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !req_i |=> !rsp_i) else $error("response without a request");

  // fifo strobes stay inside the legal range
  no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(wr_push_i && wr_full_i)) else $error("push into a full fifo");

  no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(rd_pop_i && rd_empty_i)) else $error("pop from an empty fifo");

  // irq is registered, so it follows a zero enable one cycle late
  irq_masked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (irqen_i == '0) |=> !irq_i) else $error("irq high with all sources masked");

endmodule

bind mbox_port_regs mbox_port_chk u_chk (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .req_i      (req_i),
  .rsp_i      (rsp_o),
  .wr_push_i  (wr_push_o),
  .wr_full_i  (wr_full_i),
  .rd_pop_i   (rd_pop_o),
  .rd_empty_i (rd_empty_i),
  .irq_i      (irq_o),
  .irqen_i    (irqen_q)
);

/* tb/tb_mbox.sv */
// ----------------------------------------------------------
// mailbox testbench with directed tests and random traffic
// from an lfsr, every response checked against a queue model
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_mbox;

  import mbox_cfg_pkg::*;
  import mbox_reg_pkg::*;

  localparam int unsigned TIMEOUT = 20;   // cycles to wait for rsp_o
  localparam int unsigned N_RAND  = 400;

  logic        clk, arst_n;
  logic [1:0]  req, we, rsp, err, irq;  // index is the port
  addr_t       addr  [2];
  data_t       wdata [2];
  data_t       rdata [2];

  // ----------------------------------------------------------
  // reference model where fifo_m[p] holds the words written by port p
  // ----------------------------------------------------------
  data_t    fifo_m  [2][$];
  cnt_t     wirqt_m [2];
  cnt_t     rirqt_m [2];
  err_vec_t error_m [2];
  irq_vec_t irqs_m  [2];
  irq_vec_t irqen_m [2];

  logic [31:0] lfsr_q;
  int          n_checks, n_errors, test_err0;
  logic        last_err;
  data_t       last_rdata;

  tb_clk_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

  mbox_top u_dut (
    .clk_i (clk), .arst_n_i (arst_n),
    .p0_req_i (req[0]), .p0_we_i (we[0]), .p0_addr_i (addr[0]), .p0_wdata_i (wdata[0]),
    .p0_rsp_o (rsp[0]), .p0_err_o (err[0]), .p0_rdata_o (rdata[0]), .p0_irq_o (irq[0]),
    .p1_req_i (req[1]), .p1_we_i (we[1]), .p1_addr_i (addr[1]), .p1_wdata_i (wdata[1]),
    .p1_rsp_o (rsp[1]), .p1_err_o (err[1]), .p1_rdata_o (rdata[1]), .p1_irq_o (irq[1])
  );

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // status as seen by port p
  function automatic logic [3:0] status_m(input int p);
    logic [3:0] s;
    s           = '0;
    s[ST_EMPTY] = (fifo_m[1-p].size() == 0);
    s[ST_FULL]  = (fifo_m[p].size() == DEPTH);
    s[ST_WTHR]  = (fifo_m[p].size() > wirqt_m[p]);
    s[ST_RTHR]  = (fifo_m[1-p].size() > rirqt_m[p]);
    return s;
  endfunction

  // expected response of one access, then the model state after it
  task automatic predict(input int p, input logic w, input addr_t a, input data_t d,
                         output logic e, output data_t r);
    irq_vec_t   setv, clrv;
    logic [3:0] st;
    int         o;
    o    = 1 - p;
    setv = '0;
    clrv = '0;
    e    = 1'b0;
    r    = '0;
    st   = status_m(p);
    if (a >= NUM_REGS) begin
      e = 1'b1;                       // index outside the map reads zero
    end else if (!w) begin
      case (a)
        REG_MBOXW:  r = MBOXW_READ_VAL;
        REG_MBOXR: begin
          if (fifo_m[o].size() == 0) begin
            r = EMPTY_READ_VAL;
            e = 1'b1;
            error_m[p][ERR_RD_EMPTY] = 1'b1;
            setv[IRQ_ERR] = 1'b1;
          end else begin
            r = fifo_m[o].pop_front();
          end
        end
        REG_STATUS: r = data_t'(st);
        REG_ERROR: begin
          r = data_t'(error_m[p]);
          error_m[p] = '0;            // clear on read
        end
        REG_WIRQT:  r = data_t'(wirqt_m[p]);
        REG_RIRQT:  r = data_t'(rirqt_m[p]);
        REG_IRQS:   r = data_t'(irqs_m[p]);
        REG_IRQEN:  r = data_t'(irqen_m[p]);
        REG_IRQP:   r = data_t'(irqs_m[p] & irqen_m[p]);
        default:    r = '0;           // CTRL
      endcase
    end else begin
      case (a)
        REG_MBOXW: begin
          if (fifo_m[p].size() == DEPTH) begin
            e = 1'b1;
            error_m[p][ERR_WR_FULL] = 1'b1;
            setv[IRQ_ERR] = 1'b1;
          end else begin
            fifo_m[p].push_back(d);
          end
        end
        REG_WIRQT: wirqt_m[p] = (d >= data_t'(DEPTH - 1)) ? cnt_t'(DEPTH - 1) : cnt_t'(d);
        REG_RIRQT: rirqt_m[p] = (d >= data_t'(DEPTH - 1)) ? cnt_t'(DEPTH - 1) : cnt_t'(d);
        REG_IRQS:  clrv = irq_vec_t'(d);
        REG_IRQEN: irqen_m[p] = irq_vec_t'(d);
        REG_CTRL: begin
          if (d[CTRL_FLUSH_W]) fifo_m[p].delete();
          if (d[CTRL_FLUSH_R]) fifo_m[o].delete();
        end
        default: e = 1'b1;            // read only register
      endcase
    end
    irqs_m[p] = (irqs_m[p] | setv) & ~clrv;   // ack after set
    // threshold levels of the new state set IRQS on both ports
    for (int q = 0; q < 2; q++) begin
      st = status_m(q);
      irqs_m[q][IRQ_W] = irqs_m[q][IRQ_W] | st[ST_WTHR];
      irqs_m[q][IRQ_R] = irqs_m[q][IRQ_R] | st[ST_RTHR];
    end
  endtask

  task automatic compare(input string name, input data_t got, input data_t exp);
    n_checks++;
    assert (got === exp) else begin
      $display("Mismatch %s: got %h exp %h", name, got, exp);
      n_errors++;
    end
  endtask

  // one request, wait for its response, then two idle cycles for irq_o
  task automatic access(input int p, input logic w, input addr_t a, input data_t d);
    logic  exp_err;
    data_t exp_rdata;
    int    n;
    req[p]   = 1'b1;
    we[p]    = w;
    addr[p]  = a;
    wdata[p] = d;
    predict(p, w, a, d, exp_err, exp_rdata);
    @(posedge clk);
    #2;
    req[p] = 1'b0;
    n      = 0;
    while (!rsp[p] && n < TIMEOUT) begin
      @(posedge clk);
      #2;
      n++;
    end
    n_checks++;
    assert (rsp[p]) else begin
      $display("port %0d gave no response within %0d cycles", p, TIMEOUT);
      n_errors++;
    end
    n_checks++;
    assert (n == 0) else begin
      $display("port %0d responded %0d cycles later than one cycle", p, n);
      n_errors++;
    end
    compare($sformatf("p%0d err_o", p), data_t'(err[p]), data_t'(exp_err));
    compare($sformatf("p%0d rdata_o", p), rdata[p], exp_rdata);
    last_err   = err[p];
    last_rdata = rdata[p];
    repeat (2) @(posedge clk);
    #2;
    for (int q = 0; q < 2; q++) begin
      compare($sformatf("p%0d irq_o", q), data_t'(irq[q]),
              data_t'(|(irqs_m[q] & irqen_m[q])));
    end
  endtask

  task automatic end_test(input string name);
    if (n_errors == test_err0) begin
      $display("test %-9s ok", name);
    end else begin
      $display("test %-9s %0d errors", name, n_errors - test_err0);
    end
    test_err0 = n_errors;
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    addr_t ro [4];
    data_t sent [4];
    int    n, p;
    logic  w;
    addr_t a;
    data_t d;
    ro     = '{REG_MBOXR, REG_STATUS, REG_ERROR, REG_IRQP};
    req    = '0;
    we     = '0;
    addr   = '{default: '0};
    wdata  = '{default: '0};
    lfsr_q = 32'h3def;
    {n_checks, n_errors, test_err0} = '0;
    for (int i = 0; i < 2; i++) begin
      {wirqt_m[i], rirqt_m[i], error_m[i], irqs_m[i], irqen_m[i]} = '0;
    end
    n = 0;
    while (arst_n !== 1'b1 && n < 100) begin
      @(posedge clk);
      n++;
    end
    assert (arst_n) else begin
      $display("reset was never released");
      n_errors++;
    end
    #2;

    // reset values where only STATUS shows the empty incoming fifo
    compare("p0 irq_o", data_t'(irq[0]), '0);
    compare("p1 irq_o", data_t'(irq[1]), '0);
    for (int q = 0; q < 2; q++) begin
      for (int r = REG_STATUS; r <= REG_CTRL; r++) begin
        access(q, 1'b0, addr_t'(r), '0);
        compare("reset rdata_o", last_rdata, (r == REG_STATUS) ? data_t'(1) << ST_EMPTY : '0);
      end
    end
    end_test("reset");

    for (int i = 0; i < 4; i++) begin
      sent[i] = rand_bits(32);
      access(0, 1'b1, REG_MBOXW, sent[i]);
    end
    for (int i = 0; i < 4; i++) begin
      access(1, 1'b0, REG_MBOXR, '0);
      compare("p1 MBOXR order", last_rdata, sent[i]);
    end
    access(1, 1'b1, REG_MBOXW, 32'h1234_5678);  // other direction
    access(0, 1'b0, REG_MBOXR, '0);
    compare("p0 MBOXR", last_rdata, 32'h1234_5678);
    access(0, 1'b0, REG_MBOXW, '0);
    compare("MBOXW read", last_rdata, MBOXW_READ_VAL);
    end_test("transfer");

    for (int i = 0; i <= DEPTH; i++) begin
      access(1, 1'b1, REG_MBOXW, rand_bits(32));   // last one overflows
    end
    compare("overflow err_o", data_t'(last_err), 1);
    access(1, 1'b0, REG_MBOXR, '0);
    compare("empty rdata_o", last_rdata, EMPTY_READ_VAL);
    compare("empty err_o", data_t'(last_err), 1);
    access(1, 1'b0, REG_ERROR, '0);
    compare("ERROR", last_rdata, (1 << ERR_RD_EMPTY) | (1 << ERR_WR_FULL));
    access(1, 1'b0, REG_ERROR, '0);
    compare("ERROR after read", last_rdata, '0);
    access(1, 1'b0, REG_IRQS, '0);
    compare("IRQS err bit", data_t'(last_rdata[IRQ_ERR]), 1);
    end_test("errors");

    access(0, 1'b1, REG_WIRQT, 32'd15);
    access(0, 1'b0, REG_WIRQT, '0);
    compare("WIRQT clamp", last_rdata, DEPTH - 1);
    access(1, 1'b1, REG_RIRQT, 32'hFFFF_FFFF);
    access(1, 1'b0, REG_RIRQT, '0);
    compare("RIRQT clamp", last_rdata, DEPTH - 1);
    access(0, 1'b1, REG_WIRQT, 2);
    access(1, 1'b1, REG_RIRQT, 2);
    access(0, 1'b1, REG_IRQS, 7);
    access(1, 1'b1, REG_IRQS, 7);
    access(0, 1'b1, REG_IRQEN, 1 << IRQ_W);
    for (int i = 0; i < 3; i++) begin
      access(0, 1'b1, REG_MBOXW, rand_bits(32));   // count 3 > 2
    end
    access(0, 1'b0, REG_STATUS, '0);
    compare("STATUS wthr", data_t'(last_rdata[ST_WTHR]), 1);
    compare("p0 irq_o enabled", data_t'(irq[0]), 1);
    compare("p1 irq_o masked", data_t'(irq[1]), 0);  // RTHR set but not enabled
    access(1, 1'b0, REG_IRQP, '0);
    compare("p1 IRQP", last_rdata, '0);
    access(1, 1'b1, REG_IRQEN, 1 << IRQ_R);
    compare("p1 irq_o enabled", data_t'(irq[1]), 1);
    access(0, 1'b1, REG_IRQS, 1 << IRQ_W);   // condition persists
    compare("p0 irq_o held", data_t'(irq[0]), 1);
    access(1, 1'b0, REG_MBOXR, '0);          // back to the threshold
    access(1, 1'b1, REG_IRQS, 1 << IRQ_R);
    compare("p1 irq_o cleared", data_t'(irq[1]), 0);
    access(0, 1'b1, REG_IRQS, 1 << IRQ_W);
    compare("p0 irq_o cleared", data_t'(irq[0]), 0);
    end_test("threshold");

    access(0, 1'b1, REG_CTRL, 1 << CTRL_FLUSH_R);  // full fifo from the error test
    access(0, 1'b0, REG_STATUS, '0);
    compare("p0 STATUS empty", data_t'(last_rdata[ST_EMPTY]), 1);
    access(0, 1'b1, REG_CTRL, 1 << CTRL_FLUSH_W);
    access(1, 1'b0, REG_STATUS, '0);
    compare("p1 STATUS empty", data_t'(last_rdata[ST_EMPTY]), 1);
    foreach (ro[i]) begin
      access(1, 1'b1, ro[i], '0);
      compare("read only err_o", data_t'(last_err), 1);
    end
    for (int r = NUM_REGS; r < 16; r++) begin
      access(0, r[0], addr_t'(r), '0);   // reads and writes alternate
      compare("bad index err_o", data_t'(last_err), 1);
    end
    end_test("control");

    for (int i = 0; i < N_RAND; i++) begin
      p = rand_bits(1);
      w = rand_bits(1);
      a = addr_t'(rand_bits(ADDR_W));
      if (a >= 12) begin
        a = a[0] ? REG_MBOXR : REG_MBOXW;  // more fifo traffic
      end
      d = (a == REG_MBOXW) ? rand_bits(32) : rand_bits(4);
      access(p, w, a, d);
    end
    end_test("random");

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/mbox_cfg_pkg.sv
verilog/mbox_reg_pkg.sv
verilog/mbox_fifo.sv
verilog/mbox_port_regs.sv
verilog/mbox_top.sv
tb/tb_clk_gen.sv
tb/mbox_port_chk.sv
tb/tb_mbox.sv

/* Bender.yml */
package:
  name: mbox

sources:
  # design, packages first
  - files:
      - verilog/mbox_cfg_pkg.sv
      - verilog/mbox_reg_pkg.sv
      - verilog/mbox_fifo.sv
      - verilog/mbox_port_regs.sv
      - verilog/mbox_top.sv

  # testbench, top module tb_mbox
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/mbox_port_chk.sv
      - tb/tb_mbox.sv
